// File: hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;
  localparam int OFFSET_W = 3;           // byte offset within a word
  localparam int STRB_W   = DATA_W / 8;
  localparam int LINE_W   = ADDR_W - OFFSET_W;

  // word address, low bits select the set
  typedef logic [LINE_W-1:0] line_addr_t;

  // full line address kept as tag, no width depends on set count
  typedef struct packed {
    logic       valid;
    logic       dirty;
    line_addr_t line;
  } tag_entry_t;

  typedef struct packed {
    line_addr_t        line;
    logic [DATA_W-1:0] data;   // unused on refill reads
  } mem_req_t;

  typedef struct packed {
    logic       hit;
    logic       hit_way;
    logic       victim_way;
    tag_entry_t victim;        // passed through for writeback
  } hit_info_t;

endpackage

`default_nettype wire

// File: hdl/way_store.sv
`default_nettype none

module way_store #(
  parameter int  DEPTH   = 64,
  parameter type entry_t = logic [63:0]
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     en_i,
  input  wire logic                     we_i,
  input  wire logic [$clog2(DEPTH)-1:0] idx_i,
  input  wire entry_t                   wdata_i,
  output entry_t                        rdata_o
);

  entry_t mem [DEPTH];

  // read-first, old word comes out on a write
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[idx_i] <= wdata_i;
      end
      rdata_o <= mem[idx_i];
    end
  end

  // index comes from the controller's held request or sweep counter
  a_idx_known: assert property (
    @(posedge clk) disable iff (rst) en_i |-> !$isunknown(idx_i)
  );

endmodule

`default_nettype wire

// File: hdl/tag_compare.sv
`default_nettype none

module tag_compare (
  input  wire dcache_pkg::tag_entry_t entry0_i,
  input  wire dcache_pkg::tag_entry_t entry1_i,
  input  wire dcache_pkg::line_addr_t line_i,
  input  wire logic                   lru_way_i,
  output dcache_pkg::hit_info_t       hit_o
);

  import dcache_pkg::*;

  logic hit0;
  logic hit1;
  logic victim_way;

  assign hit0 = entry0_i.valid && (entry0_i.line == line_i);
  assign hit1 = entry1_i.valid && (entry1_i.line == line_i);

  // fill an empty way before evicting
  always_comb begin
    if (!entry0_i.valid) begin
      victim_way = 1'b0;
    end else if (!entry1_i.valid) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_way_i;
    end
  end

  assign hit_o.hit        = hit0 || hit1;
  assign hit_o.hit_way    = hit1;
  assign hit_o.victim_way = victim_way;
  assign hit_o.victim     = victim_way ? entry1_i : entry0_i;

  // a refill only ever lands in the way that missed, so a line lives in one way
  always_comb begin
    a_one_way: assert final (!(hit0 === 1'b1 && hit1 === 1'b1));
  end

endmodule

`default_nettype wire

// File: hdl/lru_table.sv
`default_nettype none

module lru_table #(
  parameter int SETS = 64
) (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic [$clog2(SETS)-1:0] idx_i,
  input  wire logic                    touch_i,
  input  wire logic                    touch_way_i,
  output logic                         lru_way_o
);

  logic [SETS-1:0] lru_q;   // names the least recently used way

  always_ff @(posedge clk) begin
    if (rst) begin
      lru_q <= '0;
    end else if (touch_i) begin
      lru_q[idx_i] <= ~touch_way_i;  // other way is now older
    end
  end

  assign lru_way_o = lru_q[idx_i];

endmodule

`default_nettype wire

// File: hdl/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl #(
  parameter int SETS = 64
) (
  input  wire logic                            clk,
  input  wire logic                            rst,
  // cpu read
  input  wire logic                            ar_valid_i,
  output logic                                 ar_ready_o,
  input  wire logic [dcache_pkg::ADDR_W-1:0]   ar_addr_i,
  output logic                                 r_valid_o,
  input  wire logic                            r_ready_i,
  output logic [dcache_pkg::DATA_W-1:0]        r_data_o,
  // cpu write
  input  wire logic                            aw_valid_i,
  output logic                                 aw_ready_o,
  input  wire logic [dcache_pkg::ADDR_W-1:0]   aw_addr_i,
  input  wire logic                            w_valid_i,
  output logic                                 w_ready_o,
  input  wire logic [dcache_pkg::STRB_W-1:0]   w_strb_i,
  input  wire logic [dcache_pkg::DATA_W-1:0]   w_data_i,
  output logic                                 b_valid_o,
  input  wire logic                            b_ready_i,
  // memory handshakes
  output logic                                 mem_ar_valid_o,
  input  wire logic                            mem_ar_ready_i,
  input  wire logic                            mem_r_valid_i,
  output logic                                 mem_r_ready_o,
  input  wire logic [dcache_pkg::DATA_W-1:0]   mem_r_data_i,
  output logic                                 mem_aw_valid_o,
  input  wire logic                            mem_aw_ready_i,
  output logic                                 mem_w_valid_o,
  input  wire logic                            mem_w_ready_i,
  input  wire logic                            mem_b_valid_i,
  output logic                                 mem_b_ready_o,
  output dcache_pkg::mem_req_t                 mem_rd_req_o,
  output dcache_pkg::mem_req_t                 mem_wr_req_o,
  // way stores
  output logic [$clog2(SETS)-1:0]              idx_o,
  output logic [1:0]                           tag_we_o,
  output logic [1:0]                           data_we_o,
  output dcache_pkg::tag_entry_t               tag_wdata_o,
  output logic [dcache_pkg::DATA_W-1:0]        data_wdata_o,
  input  wire dcache_pkg::tag_entry_t          tag_rdata0_i,
  input  wire dcache_pkg::tag_entry_t          tag_rdata1_i,
  input  wire logic [dcache_pkg::DATA_W-1:0]   data_rdata0_i,
  input  wire logic [dcache_pkg::DATA_W-1:0]   data_rdata1_i,
  // compare and lru
  input  wire dcache_pkg::hit_info_t           hit_i,
  output dcache_pkg::line_addr_t               held_line_o,
  output logic                                 touch_o,
  output logic                                 touch_way_o
);

  import dcache_pkg::*;

  localparam int IDX_W = $clog2(SETS);

  typedef enum logic [3:0] {
    S_SWEEP,
    S_IDLE,
    S_LOOKUP,
    S_COMPARE,
    S_HIT,
    S_WB_ADDR,
    S_WB_DATA,
    S_WB_RESP,
    S_RF_ADDR,
    S_RF_DATA
  } state_t;

  state_t            state_q;
  logic [IDX_W-1:0]  sweep_cnt_q;
  logic              is_wr_q;
  logic              r_valid_q;
  logic              w_ready_q;
  logic              b_valid_q;
  line_addr_t        held_line_q;
  logic              way_q;        // hit way, or victim way during a miss
  logic [DATA_W-1:0] r_data_q;
  mem_req_t          wb_req_q;
  logic              ar_fire;
  logic              aw_fire;
  logic              w_fire;
  logic [DATA_W-1:0] hit_data;
  logic [DATA_W-1:0] victim_data;
  logic [DATA_W-1:0] way_data;
  tag_entry_t        way_entry;

  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_w,
    input logic [DATA_W-1:0] new_w,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign ar_ready_o = (state_q == S_IDLE);
  assign aw_ready_o = (state_q == S_IDLE) && !ar_valid_i;  // read wins
  assign ar_fire    = ar_valid_i && ar_ready_o;
  assign aw_fire    = aw_valid_i && aw_ready_o;
  assign w_fire     = w_valid_i && w_ready_o;

  assign hit_data    = hit_i.hit_way ? data_rdata1_i : data_rdata0_i;
  assign victim_data = hit_i.victim_way ? data_rdata1_i : data_rdata0_i;
  assign way_data    = way_q ? data_rdata1_i : data_rdata0_i;
  assign way_entry   = way_q ? tag_rdata1_i : tag_rdata0_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_SWEEP;
      sweep_cnt_q <= '0;
      is_wr_q     <= 1'b0;
      r_valid_q   <= 1'b0;
      w_ready_q   <= 1'b0;
      b_valid_q   <= 1'b0;
    end else begin
      case (state_q)
        S_SWEEP: begin
          sweep_cnt_q <= sweep_cnt_q + 1'b1;
          if (sweep_cnt_q == IDX_W'(SETS - 1)) begin
            state_q <= S_IDLE;
          end
        end
        S_IDLE: begin
          if (ar_fire) begin
            is_wr_q <= 1'b0;
            state_q <= S_LOOKUP;
          end else if (aw_fire) begin
            is_wr_q <= 1'b1;
            state_q <= S_LOOKUP;
          end
        end
        S_LOOKUP: state_q <= S_COMPARE;  // stores read the held set
        S_COMPARE: begin
          if (hit_i.hit) begin
            state_q <= S_HIT;
            if (is_wr_q) begin
              w_ready_q <= 1'b1;
            end else begin
              r_valid_q <= 1'b1;
            end
          end else if (hit_i.victim.valid && hit_i.victim.dirty) begin
            state_q <= S_WB_ADDR;
          end else begin
            state_q <= S_RF_ADDR;
          end
        end
        S_HIT: begin
          if (r_valid_q) begin
            if (r_ready_i) begin
              r_valid_q <= 1'b0;
              state_q   <= S_IDLE;
            end
          end else if (w_ready_q) begin
            if (w_valid_i) begin
              w_ready_q <= 1'b0;
              b_valid_q <= 1'b1;
            end
          end else if (b_ready_i) begin
            b_valid_q <= 1'b0;
            state_q   <= S_IDLE;
          end
        end
        S_WB_ADDR: if (mem_aw_ready_i) state_q <= S_WB_DATA;
        S_WB_DATA: if (mem_w_ready_i)  state_q <= S_WB_RESP;
        S_WB_RESP: if (mem_b_valid_i)  state_q <= S_RF_ADDR;
        S_RF_ADDR: if (mem_ar_ready_i) state_q <= S_RF_DATA;
        S_RF_DATA: if (mem_r_valid_i)  state_q <= S_LOOKUP;  // replay as a hit
        default:   state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      held_line_q <= '0;  // set index is driven while idle
    end else if (ar_fire) begin
      held_line_q <= ar_addr_i[ADDR_W-1:OFFSET_W];
    end else if (aw_fire) begin
      held_line_q <= aw_addr_i[ADDR_W-1:OFFSET_W];
    end
    if (state_q == S_COMPARE) begin
      way_q         <= hit_i.hit ? hit_i.hit_way : hit_i.victim_way;
      r_data_q      <= hit_data;
      wb_req_q.line <= hit_i.victim.line;
      wb_req_q.data <= victim_data;
    end
  end

  // storage writes and lru touches
  always_comb begin
    tag_we_o     = 2'b00;
    data_we_o    = 2'b00;
    tag_wdata_o  = '0;
    data_wdata_o = mem_r_data_i;
    touch_o      = 1'b0;
    touch_way_o  = way_q;
    case (state_q)
      S_SWEEP: tag_we_o = 2'b11;  // invalidate both ways
      S_COMPARE: begin
        if (hit_i.hit) begin
          touch_o     = 1'b1;
          touch_way_o = hit_i.hit_way;
        end
      end
      S_HIT: begin
        if (w_fire) begin
          data_we_o[way_q]  = 1'b1;
          tag_we_o[way_q]   = 1'b1;
          data_wdata_o      = merge_bytes(way_data, w_data_i, w_strb_i);
          tag_wdata_o       = way_entry;
          tag_wdata_o.dirty = 1'b1;
        end
      end
      S_RF_DATA: begin
        if (mem_r_valid_i) begin
          data_we_o[way_q]  = 1'b1;
          tag_we_o[way_q]   = 1'b1;
          tag_wdata_o.valid = 1'b1;
          tag_wdata_o.line  = held_line_q;
          touch_o           = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign idx_o       = (state_q == S_SWEEP) ? sweep_cnt_q : held_line_q[IDX_W-1:0];
  assign held_line_o = held_line_q;

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign w_ready_o = w_ready_q;
  assign b_valid_o = b_valid_q;

  assign mem_aw_valid_o = (state_q == S_WB_ADDR);
  assign mem_w_valid_o  = (state_q == S_WB_DATA);
  assign mem_b_ready_o  = (state_q == S_WB_RESP);
  assign mem_ar_valid_o = (state_q == S_RF_ADDR);
  assign mem_r_ready_o  = (state_q == S_RF_DATA);

  assign mem_wr_req_o      = wb_req_q;
  assign mem_rd_req_o.line = held_line_q;
  assign mem_rd_req_o.data = '0;

  a_ar_r_excl: assert property (
    @(posedge clk) disable iff (rst) !(ar_ready_o && r_valid_o)
  );

  // read response holds until the cpu takes it
  a_r_hold: assert property (
    @(posedge clk) disable iff (rst)
      r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o)
  );

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
`default_nettype none

module dcache_top #(
  parameter int SETS = 64
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  // cpu side
  input  wire logic                          ar_valid_i,
  output logic                               ar_ready_o,
  input  wire logic [dcache_pkg::ADDR_W-1:0] ar_addr_i,
  output logic                               r_valid_o,
  input  wire logic                          r_ready_i,
  output logic [dcache_pkg::DATA_W-1:0]      r_data_o,
  input  wire logic                          aw_valid_i,
  output logic                               aw_ready_o,
  input  wire logic [dcache_pkg::ADDR_W-1:0] aw_addr_i,
  input  wire logic                          w_valid_i,
  output logic                               w_ready_o,
  input  wire logic [dcache_pkg::STRB_W-1:0] w_strb_i,
  input  wire logic [dcache_pkg::DATA_W-1:0] w_data_i,
  output logic                               b_valid_o,
  input  wire logic                          b_ready_i,
  // memory side
  output logic                               mem_ar_valid_o,
  input  wire logic                          mem_ar_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0]      mem_ar_addr_o,
  input  wire logic                          mem_r_valid_i,
  output logic                               mem_r_ready_o,
  input  wire logic [dcache_pkg::DATA_W-1:0] mem_r_data_i,
  output logic                               mem_aw_valid_o,
  input  wire logic                          mem_aw_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0]      mem_aw_addr_o,
  output logic                               mem_w_valid_o,
  input  wire logic                          mem_w_ready_i,
  output logic [dcache_pkg::DATA_W-1:0]      mem_w_data_o,
  input  wire logic                          mem_b_valid_i,
  output logic                               mem_b_ready_o
);

  import dcache_pkg::*;

  localparam int IDX_W = $clog2(SETS);

  logic [IDX_W-1:0]  idx;
  logic [1:0]        tag_we;
  logic [1:0]        data_we;
  tag_entry_t        tag_wdata;
  logic [DATA_W-1:0] data_wdata;
  tag_entry_t        tag_rdata [2];
  logic [DATA_W-1:0] data_rdata [2];
  hit_info_t         hit_info;
  line_addr_t        held_line;
  logic              touch;
  logic              touch_way;
  logic              lru_way;
  mem_req_t          mem_rd_req;
  mem_req_t          mem_wr_req;

  // memory side takes byte addresses
  assign mem_ar_addr_o = {mem_rd_req.line, {OFFSET_W{1'b0}}};
  assign mem_aw_addr_o = {mem_wr_req.line, {OFFSET_W{1'b0}}};
  assign mem_w_data_o  = mem_wr_req.data;

  for (genvar w = 0; w < 2; w++) begin : g_way
    way_store #(
      .DEPTH   (SETS),
      .entry_t (tag_entry_t)
    ) u_tag_store (
      .clk     (clk),
      .rst     (rst),
      .en_i    (1'b1),          // index is held, so reading every cycle is harmless
      .we_i    (tag_we[w]),
      .idx_i   (idx),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );

    way_store #(
      .DEPTH   (SETS),
      .entry_t (logic [DATA_W-1:0])
    ) u_data_store (
      .clk     (clk),
      .rst     (rst),
      .en_i    (1'b1),
      .we_i    (data_we[w]),
      .idx_i   (idx),
      .wdata_i (data_wdata),
      .rdata_o (data_rdata[w])
    );
  end

  tag_compare u_tag_compare (
    .entry0_i  (tag_rdata[0]),
    .entry1_i  (tag_rdata[1]),
    .line_i    (held_line),
    .lru_way_i (lru_way),
    .hit_o     (hit_info)
  );

  lru_table #(
    .SETS (SETS)
  ) u_lru_table (
    .clk         (clk),
    .rst         (rst),
    .idx_i       (idx),
    .touch_i     (touch),
    .touch_way_i (touch_way),
    .lru_way_o   (lru_way)
  );

  dcache_ctrl #(
    .SETS (SETS)
  ) u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .ar_addr_i      (ar_addr_i),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i),
    .r_data_o       (r_data_o),
    .aw_valid_i     (aw_valid_i),
    .aw_ready_o     (aw_ready_o),
    .aw_addr_i      (aw_addr_i),
    .w_valid_i      (w_valid_i),
    .w_ready_o      (w_ready_o),
    .w_strb_i       (w_strb_i),
    .w_data_i       (w_data_i),
    .b_valid_o      (b_valid_o),
    .b_ready_i      (b_ready_i),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .mem_aw_valid_o (mem_aw_valid_o),
    .mem_aw_ready_i (mem_aw_ready_i),
    .mem_w_valid_o  (mem_w_valid_o),
    .mem_w_ready_i  (mem_w_ready_i),
    .mem_b_valid_i  (mem_b_valid_i),
    .mem_b_ready_o  (mem_b_ready_o),
    .mem_rd_req_o   (mem_rd_req),
    .mem_wr_req_o   (mem_wr_req),
    .idx_o          (idx),
    .tag_we_o       (tag_we),
    .data_we_o      (data_we),
    .tag_wdata_o    (tag_wdata),
    .data_wdata_o   (data_wdata),
    .tag_rdata0_i   (tag_rdata[0]),
    .tag_rdata1_i   (tag_rdata[1]),
    .data_rdata0_i  (data_rdata[0]),
    .data_rdata1_i  (data_rdata[1]),
    .hit_i          (hit_info),
    .held_line_o    (held_line),
    .touch_o        (touch),
    .touch_way_o    (touch_way)
  );

endmodule

`default_nettype wire

// File: verif/mem_model.sv
`default_nettype none

module mem_model (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [2:0]                    rdy_i,  // ar, aw, w readies
  input  wire logic                          mem_ar_valid_i,
  output logic                               mem_ar_ready_o,
  input  wire logic [dcache_pkg::ADDR_W-1:0] mem_ar_addr_i,
  output logic                               mem_r_valid_o,
  input  wire logic                          mem_r_ready_i,
  output logic [dcache_pkg::DATA_W-1:0]      mem_r_data_o,
  input  wire logic                          mem_aw_valid_i,
  output logic                               mem_aw_ready_o,
  input  wire logic [dcache_pkg::ADDR_W-1:0] mem_aw_addr_i,
  input  wire logic                          mem_w_valid_i,
  output logic                               mem_w_ready_o,
  input  wire logic [dcache_pkg::DATA_W-1:0] mem_w_data_i,
  output logic                               mem_b_valid_o,
  input  wire logic                          mem_b_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  import dcache_pkg::*;

  logic [DATA_W-1:0] mem [line_addr_t];  // sparse, only written lines
  line_addr_t        aw_line_q;

  function automatic logic [DATA_W-1:0] pattern_word(input line_addr_t l);
    logic [31:0] a;
    a = {3'b000, l};
    return {a ^ 32'hc3a5_0f1e, a * 32'h9e37_79b1};
  endfunction

  assign mem_ar_ready_o = rdy_i[0];
  assign mem_aw_ready_o = rdy_i[1];
  assign mem_w_ready_o  = rdy_i[2];

  always @(posedge clk) begin
    if (rst) begin
      mem_r_valid_o <= 1'b0;
      mem_b_valid_o <= 1'b0;
    end else begin
      if (mem_ar_valid_i && mem_ar_ready_o) begin
        mem_r_valid_o <= 1'b1;
        if (mem.exists(mem_ar_addr_i[ADDR_W-1:OFFSET_W])) begin
          mem_r_data_o <= mem[mem_ar_addr_i[ADDR_W-1:OFFSET_W]];
        end else begin
          mem_r_data_o <= pattern_word(mem_ar_addr_i[ADDR_W-1:OFFSET_W]);
        end
      end else if (mem_r_valid_o && mem_r_ready_i) begin
        mem_r_valid_o <= 1'b0;
      end
      if (mem_aw_valid_i && mem_aw_ready_o) begin
        aw_line_q <= mem_aw_addr_i[ADDR_W-1:OFFSET_W];
      end
      if (mem_w_valid_i && mem_w_ready_o) begin
        mem[aw_line_q] = mem_w_data_i;
        mem_b_valid_o <= 1'b1;
      end else if (mem_b_valid_o && mem_b_ready_i) begin
        mem_b_valid_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/dcache_checker.sv
`default_nettype none

// watches the DUT ports through the testbench nets
module dcache_checker #(
  parameter int SETS = 64
) (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic [2:0] test_id_i,
  input  wire logic       test_done_i,
  input  wire logic       run_done_i,
  output int              err_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  import dcache_pkg::*;

  logic [DATA_W-1:0] shadow [line_addr_t];
  bit                dirty_q [line_addr_t];  // written, not yet written back
  int         cyc, sweep_cyc, rd_start, errs, checks, errs_snap, checks_snap;
  int         reads_acc, reads_resp, writes_acc, writes_resp, wb_cnt;
  int         wb_resp, rf_cnt, rf_resp;
  bit         rd_pend, wr_pend, rd_miss, wb_seen, any_req, r_valid_prev, reset_done;
  line_addr_t rd_line, wr_line, wb_line, rf_line;

  assign err_cnt_o = errs;

  function automatic logic [DATA_W-1:0] pattern_word(input line_addr_t l);
    logic [31:0] a;
    a = {3'b000, l};
    return {a ^ 32'hc3a5_0f1e, a * 32'h9e37_79b1};
  endfunction

  // reference value of a line as the CPU has written it
  function automatic logic [DATA_W-1:0] expected_word(input line_addr_t l);
    if (shadow.exists(l)) begin
      return shadow[l];
    end
    return pattern_word(l);
  endfunction

  function automatic logic [DATA_W-1:0] merge_strobed(input logic [DATA_W-1:0] old_w,
      input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  function automatic int dirty_in_set(input int s, input line_addr_t skip);
    int n;
    n = 0;
    foreach (dirty_q[l]) begin
      if ((int'(l) % SETS) == s && l != skip) n++;
    end
    return n;
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1: return "cold read misses";
      3'd2: return "read hits";
      3'd3: return "write then read";
      3'd4: return "dirty eviction";
      default: return "back-pressure";
    endcase
  endfunction

  task automatic report_error(input string msg);
    errs++;
    $display("%s", msg);
  endtask

  task automatic check_word(input string sig, input logic [DATA_W-1:0] exp_w,
      input logic [DATA_W-1:0] act_w);
    checks++;
    if (exp_w !== act_w) report_error($sformatf("ERR %s expected %h actual %h", sig, exp_w, act_w));
  endtask

  task automatic print_test(input string name);
    $display("test %-18s checks %0d errors %0d", name, checks - checks_snap, errs - errs_snap);
    checks_snap = checks;
    errs_snap = errs;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      sweep_cyc = 0;
    end else begin
      cyc++;
      if (!reset_done) begin
        checks++;
        if (sweep_cyc < SETS && (tb_top.ar_ready_o || tb_top.aw_ready_o)) begin
          report_error("a request ready was high during the reset sweep");
        end else if (sweep_cyc == SETS) begin
          if (!tb_top.ar_ready_o) report_error("ar_ready_o did not rise after the reset sweep");
          reset_done = 1'b1;
          print_test("reset state");
        end
        sweep_cyc++;
      end
      if (!any_req && (tb_top.mem_ar_valid_o || tb_top.mem_aw_valid_o || tb_top.mem_w_valid_o))
        report_error("memory request issued before any CPU request");
      if (tb_top.ar_valid_i && tb_top.ar_ready_o) begin
        if (rd_pend || wr_pend) report_error("read accepted while a request was in flight");
        rd_pend = 1'b1;
        rd_line = tb_top.ar_addr_i[ADDR_W-1:OFFSET_W];
        rd_start = cyc;
        {rd_miss, wb_seen, any_req} = 3'b001;
        reads_acc++;
      end
      if (tb_top.aw_valid_i && tb_top.aw_ready_o) begin
        if (rd_pend || wr_pend) report_error("write accepted while a request was in flight");
        wr_pend = 1'b1;
        wr_line = tb_top.aw_addr_i[ADDR_W-1:OFFSET_W];
        {wb_seen, any_req} = 2'b01;
        writes_acc++;
      end
      if (tb_top.r_valid_o && !r_valid_prev && rd_pend && !rd_miss) begin
        checks++;
        if (cyc - rd_start != 3)
          report_error($sformatf("read hit answered %0d cycles after ar, not 2",
                                 cyc - rd_start - 1));
      end
      r_valid_prev = tb_top.r_valid_o;
      if (tb_top.r_valid_o && tb_top.r_ready_i) begin
        reads_resp++;
        if (!rd_pend) report_error("read response without a pending read");
        else check_word("r_data_o", expected_word(rd_line), tb_top.r_data_o);
        rd_pend = 1'b0;
      end
      if (tb_top.w_valid_i && tb_top.w_ready_o) begin
        if (!wr_pend) report_error("write data taken without a pending write");
        shadow[wr_line] = merge_strobed(expected_word(wr_line), tb_top.w_data_i, tb_top.w_strb_i);
        dirty_q[wr_line] = 1'b1;
      end
      if (tb_top.b_valid_o && tb_top.b_ready_i) begin
        writes_resp++;
        if (!wr_pend) report_error("write response without a pending write");
        wr_pend = 1'b0;
      end
      if (tb_top.mem_aw_valid_o && tb_top.mem_aw_ready_i) begin
        wb_line = tb_top.mem_aw_addr_o[ADDR_W-1:OFFSET_W];
        if (tb_top.mem_aw_addr_o[OFFSET_W-1:0] != '0) report_error("writeback address not aligned");
      end
      if (tb_top.mem_w_valid_o && tb_top.mem_w_ready_i) begin
        check_word("mem_w_data_o", expected_word(wb_line), tb_top.mem_w_data_o);
        dirty_q.delete(wb_line);
        wb_seen = 1'b1;
        wb_cnt++;
      end
      if (tb_top.mem_b_valid_i && tb_top.mem_b_ready_o) wb_resp++;
      if (tb_top.mem_ar_valid_o && tb_top.mem_ar_ready_i) begin
        rf_line = tb_top.mem_ar_addr_o[ADDR_W-1:OFFSET_W];
        rd_miss = 1'b1;
        rf_cnt++;
        checks++;
        if (dirty_in_set(int'(rf_line) % SETS, rf_line) >= 2 && !wb_seen)
          report_error($sformatf("refill read for set %0d came without writeback of %s",
                                 int'(rf_line) % SETS, "its dirty victim"));
      end
      if (tb_top.mem_r_valid_i && tb_top.mem_r_ready_o) rf_resp++;
      if (test_done_i) print_test(test_name(test_id_i));
      if (run_done_i) begin
        if (reads_acc != reads_resp || writes_acc != writes_resp || rd_pend || wr_pend)
          report_error("accepted requests and responses do not match");
        if (rf_cnt != rf_resp || wb_cnt != wb_resp)
          report_error("memory responses were not all taken by the DUT");
        $display("reads %0d/%0d writes %0d/%0d refills %0d/%0d writebacks %0d/%0d %s",
                 reads_acc, reads_resp, writes_acc, writes_resp, rf_cnt, rf_resp,
                 wb_cnt, wb_resp, $sformatf("checks %0d errors %0d", checks, errs));
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_top.sv
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  import dcache_pkg::*;

  localparam int SETS    = 64;
  localparam int NUM_OPS = 312;  // 24 + 16 + 32 + 2 * 120

  logic              clk = 1'b0;
  logic              rst;
  logic              ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
  logic              aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic [ADDR_W-1:0] ar_addr_i, aw_addr_i, mem_ar_addr_o, mem_aw_addr_o;
  logic [DATA_W-1:0] r_data_o, w_data_i, mem_r_data_i, mem_w_data_o;
  logic [STRB_W-1:0] w_strb_i;
  logic              mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  logic              mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
  logic              mem_b_valid_i, mem_b_ready_o;
  logic [2:0]        mem_rdy;
  logic              stall_en, test_done, run_done;
  logic [2:0]        test_id;
  logic [31:0]       lcg_q = 32'h2e33;
  logic [31:0]       stall_lcg_q = ~32'h2e33;  // separate stream for the readies
  int                err_cnt;

  always #2 clk = ~clk;

  dcache_top #(.SETS(SETS)) u_dut (.*);

  mem_model u_mem (
    .clk(clk), .rst(rst), .rdy_i(mem_rdy),
    .mem_ar_valid_i(mem_ar_valid_o), .mem_ar_ready_o(mem_ar_ready_i),
    .mem_ar_addr_i(mem_ar_addr_o), .mem_r_valid_o(mem_r_valid_i),
    .mem_r_ready_i(mem_r_ready_o), .mem_r_data_o(mem_r_data_i),
    .mem_aw_valid_i(mem_aw_valid_o), .mem_aw_ready_o(mem_aw_ready_i),
    .mem_aw_addr_i(mem_aw_addr_o), .mem_w_valid_i(mem_w_valid_o),
    .mem_w_ready_o(mem_w_ready_i), .mem_w_data_i(mem_w_data_o),
    .mem_b_valid_o(mem_b_valid_i), .mem_b_ready_i(mem_b_ready_o)
  );

  dcache_checker #(.SETS(SETS)) u_checker (
    .clk(clk), .rst(rst), .test_id_i(test_id), .test_done_i(test_done),
    .run_done_i(run_done), .err_cnt_o(err_cnt)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    lcg_q = lcg_step(lcg_q);
    return lcg_q;
  endfunction

  // 24 lines over sets 0, 9, 18 and 27
  function automatic logic [ADDR_W-1:0] line_addr(input int n, input logic [2:0] off);
    logic [LINE_W-1:0] l;
    l = LINE_W'(32'h400 + (n % 4) * 9 + (n / 4) * SETS);
    return {l, off};
  endfunction

  always @(posedge clk) begin
    stall_lcg_q = lcg_step(stall_lcg_q);
    r_ready_i <= !stall_en || stall_lcg_q[20];
    b_ready_i <= !stall_en || stall_lcg_q[21];
    mem_rdy   <= stall_lcg_q[26:24] | stall_lcg_q[30:28];
  end

  task automatic read_op(input int n);
    logic [31:0] r;
    r = rand_word();
    ar_addr_i  <= line_addr(n, r[18:16]);
    ar_valid_i <= 1'b1;
    do @(posedge clk); while (!ar_ready_o);
    ar_valid_i <= 1'b0;
    do @(posedge clk); while (!(r_valid_o && r_ready_i));
  endtask

  task automatic write_op(input int n);
    logic [31:0] r;
    r = rand_word();
    aw_addr_i  <= line_addr(n, r[18:16]);
    w_strb_i   <= r[7:0];
    w_data_i   <= {rand_word(), rand_word()};
    aw_valid_i <= 1'b1;
    w_valid_i  <= 1'b1;
    do @(posedge clk); while (!aw_ready_o);
    aw_valid_i <= 1'b0;
    do @(posedge clk); while (!w_ready_o);
    w_valid_i <= 1'b0;
    do @(posedge clk); while (!(b_valid_o && b_ready_i));
  endtask

  task automatic random_ops(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = rand_word();
      if (r[4]) write_op(int'(r[15:8]) % 24);
      else read_op(int'(r[15:8]) % 24);
    end
  endtask

  task automatic end_test(input logic [2:0] id);
    test_id   <= id;
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    {ar_valid_i, aw_valid_i, w_valid_i, r_ready_i, b_ready_i} = '0;
    {ar_addr_i, aw_addr_i, w_strb_i, w_data_i, mem_rdy} = '0;
    {stall_en, test_done, run_done, test_id} = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 24; i++) read_op(i);
    end_test(3'd1);
    for (int i = 0; i < 8; i++) begin
      read_op(i);
      read_op(i);  // second one hits
    end
    end_test(3'd2);
    for (int i = 0; i < 16; i++) begin
      write_op(i);
      read_op(i);
    end
    end_test(3'd3);
    random_ops(120);
    end_test(3'd4);
    stall_en <= 1'b1;
    random_ops(120);
    end_test(3'd5);
    run_done <= 1'b1;
    @(posedge clk);
    run_done <= 1'b0;
    repeat (2) @(posedge clk);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (NUM_OPS * 200) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", NUM_OPS * 200);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
hdl/dcache_pkg.sv
hdl/way_store.sv
hdl/tag_compare.sv
hdl/lru_table.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verif/mem_model.sv
verif/dcache_checker.sv
verif/tb_top.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_top -f all.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
